/* logic/rdu_pkg.sv */
`default_nettype none

package rdu_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int data_w  = 32;
    localparam int addr_w  = 4;
    localparam int win_len = 4;
    localparam int cnt_w   = $clog2(win_len);
    localparam int n_lane  = 2;

    // ==================================================
    // Diagnostic constants
    // ==================================================
    // First read-only row, rows 12..15 hold the test pattern
    localparam logic [addr_w-1:0] diag_base = addr_w'(12);

    // Fixed operands, index 0 sits at diag_base
    localparam logic [win_len-1:0][data_w-1:0] diag_word = {
        32'h0a5b6c7d,
        32'h1f2e3d4c,
        32'h4247f646,
        32'h413ff9c7
    };

    // Expected diagnostic sum, wraps at 2^32
    localparam logic [data_w-1:0] diag_golden =
        diag_word[0] + diag_word[1] + diag_word[2] + diag_word[3];

    // XOR pattern per lane when forced
    localparam logic [n_lane-1:0][data_w-1:0] force_mask = {32'h2, 32'h1};

    // ==================================================
    // Types
    // ==================================================
    typedef enum logic [2:0] {
        st_idle,
        st_adde,
        st_wait_lane,
        st_addq,
        st_chk,
        st_dgdt,
        st_done
    } seq_state_e;

    // Host write port, 37 bits
    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } host_wr_t;

    typedef struct packed {
        logic              req;
        logic [addr_w-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              rvalid;
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

    // Sequencer phase strobes
    typedef struct packed {
        logic adde;
        logic addq;
        logic dgdt;
        logic done;
        logic pass_diag;
    } phase_t;

    typedef struct packed {
        logic              done;
        logic [data_w-1:0] result;
    } lane_res_t;

    typedef struct packed {
        logic              done;
        logic [data_w-1:0] result;
        logic              lane;
        logic              rdu_fault;
        logic              hw_fault;
    } cal_out_t;

endpackage

`default_nettype wire

/* logic/opnd_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module opnd_mem (
    input  wire                  clk_sys,
    input  wire                  rst_sys_n,
    input  rdu_pkg::host_wr_t    host_wr,
    input  rdu_pkg::mem_req_t    rd_req,
    output rdu_pkg::mem_rsp_t    rd_rsp
);

    // Only the writable rows are stored
    logic [rdu_pkg::data_w-1:0] mem [0:rdu_pkg::diag_base-1];
    logic                       rvalid_q;
    logic [rdu_pkg::data_w-1:0] rdata_q;
    logic [1:0]                 diag_idx;

    // Offset into the diagnostic pattern
    assign diag_idx = 2'(rd_req.addr - rdu_pkg::diag_base);

    // ==================================================
    // Host write port ignores rows 12..15
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            for (int i = 0; i < int'(rdu_pkg::diag_base); i++) begin
                mem[i] <= '0;
            end
        end else if (host_wr.en && (host_wr.addr < rdu_pkg::diag_base)) begin
            mem[host_wr.addr] <= host_wr.data;
        end
    end

    // ==================================================
    // Registered read with one cycle latency
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_req.req;
        end
    end

    // Read data register
    always_ff @(posedge clk_sys) begin
        if (rd_req.req) begin
            if (rd_req.addr >= rdu_pkg::diag_base) begin
                rdata_q <= rdu_pkg::diag_word[diag_idx];
            end else begin
                rdata_q <= mem[rd_req.addr];
            end
        end
    end

    assign rd_rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* logic/mem_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arb (
    input  wire                                    clk_sys,
    input  wire                                    rst_sys_n,
    input  rdu_pkg::mem_req_t [rdu_pkg::n_lane-1:0] lane_req,
    output rdu_pkg::mem_rsp_t [rdu_pkg::n_lane-1:0] lane_rsp,
    output rdu_pkg::mem_req_t                      mem_req,
    input  rdu_pkg::mem_rsp_t                      mem_rsp
);

    logic                      last_gnt;
    logic                      pend_vld;
    logic                      pend_own;
    logic [rdu_pkg::n_lane-1:0] elig;
    logic                      gnt_vld;
    logic                      gnt_own;

    // Lane with a read in flight sits out this cycle
    // (its req is still high until rvalid lands)
    assign elig[0] = lane_req[0].req && !(pend_vld && !pend_own);
    assign elig[1] = lane_req[1].req && !(pend_vld && pend_own);

    // Round-robin pick
    always_comb begin
        gnt_vld = elig[0] | elig[1];
        if (elig[0] && elig[1]) begin
            // Both pending, other lane wins
            gnt_own = ~last_gnt;
        end else begin
            gnt_own = elig[1];
        end
    end

    assign mem_req = '{req: gnt_vld, addr: lane_req[gnt_own].addr};

    // Grant owner tracking
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            last_gnt <= 1'b0;
            pend_vld <= 1'b0;
            pend_own <= 1'b0;
        end else begin
            pend_vld <= gnt_vld;
            if (gnt_vld) begin
                last_gnt <= gnt_own;
                pend_own <= gnt_own;
            end
        end
    end

    // Response back to the owner only
    assign lane_rsp[0] = '{rvalid: mem_rsp.rvalid && !pend_own, rdata: mem_rsp.rdata};
    assign lane_rsp[1] = '{rvalid: mem_rsp.rvalid && pend_own, rdata: mem_rsp.rdata};

endmodule

`default_nettype wire

/* logic/calc_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_lane (
    input  wire                          clk_sys,
    input  wire                          rst_sys_n,
    input  rdu_pkg::phase_t              phase,
    input  wire [rdu_pkg::addr_w-1:0]    base,
    input  wire                          force_en,
    input  wire [rdu_pkg::data_w-1:0]    force_val,
    output rdu_pkg::mem_req_t            req,
    input  rdu_pkg::mem_rsp_t            rsp,
    output rdu_pkg::lane_res_t           res
);

    localparam logic [rdu_pkg::cnt_w-1:0] last_idx = rdu_pkg::cnt_w'(rdu_pkg::win_len - 1);

    logic                        req_q;
    logic [rdu_pkg::addr_w-1:0]  addr_q;
    logic [rdu_pkg::cnt_w-1:0]   cnt_q;
    logic                        done_q;
    logic [rdu_pkg::data_w-1:0]  acc_q;
    logic [rdu_pkg::data_w-1:0]  result_q;
    logic [rdu_pkg::data_w-1:0]  sum_fin;
    logic                        last_word;

    // Fourth operand arriving
    assign last_word = rsp.rvalid && (cnt_q == last_idx);

    // Final sum, corrupted when forced
    assign sum_fin = (acc_q + rsp.rdata) ^ (force_en ? force_val : '0);

    // ==================================================
    // Fetch control
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            req_q  <= 1'b0;
            addr_q <= '0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            // Done is a single pulse
            done_q <= 1'b0;
            if (phase.adde) begin
                req_q  <= 1'b1;
                addr_q <= base;
                cnt_q  <= '0;
            end else if (rsp.rvalid) begin
                // Next word, address wraps mod 16
                cnt_q  <= cnt_q + 1'b1;
                addr_q <= addr_q + 1'b1;
                if (last_word) begin
                    req_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Accumulator and result
    // ==================================================
    always_ff @(posedge clk_sys) begin
        if (phase.adde) begin
            acc_q <= '0;
        end else if (rsp.rvalid) begin
            acc_q <= acc_q + rsp.rdata;
            // Result held until next adde
            if (last_word) begin
                result_q <= sum_fin;
            end
        end
    end

    assign req = '{req: req_q, addr: addr_q};
    assign res = '{done: done_q, result: result_q};

endmodule

`default_nettype wire

/* logic/cal_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module cal_seq (
    input  wire                          clk_sys,
    input  wire                          rst_sys_n,
    input  wire                          start,
    input  wire [rdu_pkg::addr_w-1:0]    opnd_base,
    input  wire                          chn_en,
    input  wire [rdu_pkg::n_lane-1:0]    lane_done,
    input  wire                          dgd_mode,
    output rdu_pkg::phase_t              phase,
    output logic [rdu_pkg::addr_w-1:0]   base
);

    rdu_pkg::seq_state_e           state;
    logic [rdu_pkg::addr_w-1:0]    base_q;
    logic                          pass_diag;
    logic [rdu_pkg::n_lane-1:0]    done_seen;
    logic [rdu_pkg::n_lane-1:0]    done_all;

    // Lane done pulses seen so far, including this cycle
    assign done_all = done_seen | lane_done;

    // ==================================================
    // Phase FSM
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state     <= rdu_pkg::st_idle;
            base_q    <= '0;
            pass_diag <= 1'b0;
            done_seen <= '0;
        end else begin
            case (state)
                rdu_pkg::st_idle: begin
                    // Start ignored unless channel enabled
                    if (start && chn_en) begin
                        base_q <= opnd_base;
                        state  <= rdu_pkg::st_adde;
                    end
                end
                rdu_pkg::st_adde: begin
                    done_seen <= '0;
                    state     <= rdu_pkg::st_wait_lane;
                end
                rdu_pkg::st_wait_lane: begin
                    done_seen <= done_all;
                    if (&done_all) begin
                        state <= rdu_pkg::st_addq;
                    end
                end
                rdu_pkg::st_addq: begin
                    state <= pass_diag ? rdu_pkg::st_dgdt : rdu_pkg::st_chk;
                end
                rdu_pkg::st_chk: begin
                    // Mismatch flagged, rerun on diagnostic rows
                    if (dgd_mode) begin
                        pass_diag <= 1'b1;
                        state     <= rdu_pkg::st_adde;
                    end else begin
                        state <= rdu_pkg::st_done;
                    end
                end
                rdu_pkg::st_dgdt: state <= rdu_pkg::st_done;
                rdu_pkg::st_done: begin
                    pass_diag <= 1'b0;
                    state     <= rdu_pkg::st_idle;
                end
                default: state <= rdu_pkg::st_idle;
            endcase
        end
    end

    // Strobes decoded from state
    assign phase = '{adde:      state == rdu_pkg::st_adde,
                     addq:      state == rdu_pkg::st_addq,
                     dgdt:      state == rdu_pkg::st_dgdt,
                     done:      state == rdu_pkg::st_done,
                     pass_diag: pass_diag};

    assign base = pass_diag ? rdu_pkg::diag_base : base_q;

endmodule

`default_nettype wire

/* logic/rdu_diag.sv */
`timescale 1ns/100ps
`default_nettype none

module rdu_diag (
    input  wire                   clk_sys,
    input  wire                   rst_sys_n,
    input  rdu_pkg::phase_t       phase,
    input  rdu_pkg::lane_res_t    res0,
    input  rdu_pkg::lane_res_t    res1,
    output logic                  dgd_mode,
    output rdu_pkg::cal_out_t     cal_out
);

    // Normal-pass results
    logic [rdu_pkg::data_w-1:0] r0_q;
    logic [rdu_pkg::data_w-1:0] r1_q;
    logic [rdu_pkg::data_w-1:0] out_q;
    logic                       err0;
    logic                       err1;
    logic                       lane_sel;
    logic                       rdu_fault;
    logic                       hw_fault;
    logic                       done_q;
    logic                       addq_norm;
    logic                       addq_diag;

    assign addq_norm = phase.addq && !phase.pass_diag;
    assign addq_diag = phase.addq && phase.pass_diag;

    // ==================================================
    // Result capture
    // ==================================================
    always_ff @(posedge clk_sys) begin
        if (addq_norm) begin
            r0_q <= res0.result;
            r1_q <= res1.result;
        end
        // Output from the recovery lane
        if (phase.done) begin
            out_q <= lane_sel ? r1_q : r0_q;
        end
    end

    // ==================================================
    // Compare and diagnosis
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            dgd_mode  <= 1'b0;
            err0      <= 1'b0;
            err1      <= 1'b0;
            lane_sel  <= 1'b0;
            rdu_fault <= 1'b0;
            hw_fault  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= phase.done;

            // Lanes disagree, enter diagnosis once
            // no re-entry after a fault is latched
            if (addq_norm && (res0.result != res1.result) && !rdu_fault) begin
                dgd_mode <= 1'b1;
            end

            // Golden check per lane
            if (addq_diag) begin
                err0 <= (res0.result != rdu_pkg::diag_golden);
                err1 <= (res1.result != rdu_pkg::diag_golden);
            end

            if (phase.dgdt) begin
                dgd_mode <= 1'b0;
                // Prefer lane 0, fall back to lane 1
                if (!err0) begin
                    lane_sel <= 1'b0;
                end else if (!err1) begin
                    lane_sel <= 1'b1;
                end
                // Both wrong keeps previous select
                rdu_fault <= err0 | err1;
                hw_fault  <= err0 & err1;
            end
        end
    end

    assign cal_out = '{done:      done_q,
                       result:    out_q,
                       lane:      lane_sel,
                       rdu_fault: rdu_fault,
                       hw_fault:  hw_fault};

endmodule

`default_nettype wire

/* logic/rdu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rdu_top (
    input  wire                          clk_sys,
    input  wire                          rst_sys_n,
    input  rdu_pkg::host_wr_t            host_wr,
    input  wire                          start,
    input  wire [rdu_pkg::addr_w-1:0]    opnd_base,
    input  wire                          chn_en,
    input  wire [rdu_pkg::n_lane-1:0]    fault_force,
    output rdu_pkg::cal_out_t            cal_out
);

    // Shared memory port
    rdu_pkg::mem_req_t                       mem_req;
    rdu_pkg::mem_rsp_t                       mem_rsp;
    // Per-lane bus
    rdu_pkg::mem_req_t [rdu_pkg::n_lane-1:0] lane_req;
    rdu_pkg::mem_rsp_t [rdu_pkg::n_lane-1:0] lane_rsp;
    rdu_pkg::lane_res_t                      res0;
    rdu_pkg::lane_res_t                      res1;
    // Sequencer outputs
    rdu_pkg::phase_t                         phase;
    logic [rdu_pkg::addr_w-1:0]              base;
    logic                                    dgd_mode;

    // ==================================================
    // Operand storage and arbitration
    // ==================================================
    opnd_mem u_opnd_mem (
        .clk_sys, .rst_sys_n, .host_wr,
        .rd_req (mem_req),
        .rd_rsp (mem_rsp)
    );

    mem_arb u_mem_arb (
        .clk_sys, .rst_sys_n, .lane_req, .lane_rsp, .mem_req, .mem_rsp
    );

    // ==================================================
    // Redundant lanes
    // ==================================================
    calc_lane u_lane0 (
        .clk_sys, .rst_sys_n, .phase, .base,
        .force_en  (fault_force[0]),
        .force_val (rdu_pkg::force_mask[0]),
        .req       (lane_req[0]),
        .rsp       (lane_rsp[0]),
        .res       (res0)
    );

    calc_lane u_lane1 (
        .clk_sys, .rst_sys_n, .phase, .base,
        .force_en  (fault_force[1]),
        .force_val (rdu_pkg::force_mask[1]),
        .req       (lane_req[1]),
        .rsp       (lane_rsp[1]),
        .res       (res1)
    );

    // Control and diagnosis
    cal_seq u_cal_seq (
        .clk_sys, .rst_sys_n, .start, .opnd_base, .chn_en,
        .lane_done ({res1.done, res0.done}),
        .dgd_mode, .phase, .base
    );

    rdu_diag u_rdu_diag (
        .clk_sys, .rst_sys_n, .phase, .res0, .res1, .dgd_mode, .cal_out
    );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 3
) (
    input  wire  rst_req,
    output logic clk_sys,
    output logic rst_sys_n
);

    logic clk_q   = 1'b0;
    logic rst_n_q = 1'b0;
    int   rst_cnt = 0;

    // Free-running clock, first rising edge half a period in
    initial begin
        forever begin
            #(period_ns / 2);
            clk_q = ~clk_q;
        end
    end

    // Reset low over rst_cycles rising edges, at power-up and on request
    always @(posedge clk_q) begin
        if (rst_req) begin
            rst_n_q <= 1'b0;
            rst_cnt <= 0;
        end else if (!rst_n_q) begin
            if (rst_cnt == rst_cycles - 1) begin
                rst_n_q <= 1'b1;
            end
            rst_cnt <= rst_cnt + 1;
        end
    end

    assign clk_sys   = clk_q;
    assign rst_sys_n = rst_n_q;

endmodule

`default_nettype wire

/* tb/tb_rdu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rdu;

    // ==================================================
    // Run limits
    // ==================================================
    localparam int clk_period_ns = 40;
    localparam int cycle_limit   = 64;
    localparam int n_rand_writes = 24;
    localparam int n_rand_runs   = 20;
    localparam int n_wrap_runs   = 2;
    localparam int n_blocked     = 3;
    localparam int n_force0_runs = 4;
    // Every start issued including blocked ones
    localparam int n_starts =
        n_rand_runs + n_wrap_runs + n_blocked + 1 + n_force0_runs + 1;
    // Host writes and resets plus slack
    localparam int setup_cycles = 120;
    localparam longint watchdog_ns =
        longint'(clk_period_ns) * longint'(n_starts * cycle_limit + setup_cycles);

    logic                         clk_sys;
    logic                         rst_sys_n;
    logic                         rst_req;
    rdu_pkg::host_wr_t            host_wr;
    logic                         start;
    logic [rdu_pkg::addr_w-1:0]   opnd_base;
    logic                         chn_en;
    logic [rdu_pkg::n_lane-1:0]   fault_force;
    rdu_pkg::cal_out_t            cal_out;

    // Reference model state
    logic [rdu_pkg::data_w-1:0]   mirror [0:int'(rdu_pkg::diag_base)-1];
    logic                         m_lane;
    logic                         m_rdu_fault;
    logic                         m_hw_fault;
    int                           seed  = 7495;

    tb_clkgen #(.period_ns(clk_period_ns), .rst_cycles(3)) u_clkgen (
        .rst_req, .clk_sys, .rst_sys_n
    );

    rdu_top u_rdu_top (
        .clk_sys, .rst_sys_n, .host_wr, .start, .opnd_base, .chn_en, .fault_force, .cal_out
    );

    // ==================================================
    // Helpers and compare tasks
    // ==================================================
    // Inputs driven and outputs sampled 1 ns past the rising edge
    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [rdu_pkg::data_w-1:0] got,
                              input logic [rdu_pkg::data_w-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_out(input rdu_pkg::cal_out_t got, input rdu_pkg::cal_out_t exp);
        check_flag("cal_out.done", got.done, exp.done);
        check_data("cal_out.result", got.result, exp.result);
        check_flag("cal_out.lane", got.lane, exp.lane);
        check_flag("cal_out.rdu_fault", got.rdu_fault, exp.rdu_fault);
        check_flag("cal_out.hw_fault", got.hw_fault, exp.hw_fault);
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    task automatic clear_model();
        int k;
        for (k = 0; k < int'(rdu_pkg::diag_base); k++) begin
            mirror[4'(k)] = '0;
        end
        m_lane      = 1'b0;
        m_rdu_fault = 1'b0;
        m_hw_fault  = 1'b0;
    endtask

    // Writable rows come from the mirror and diagnostic rows are fixed
    function automatic logic [rdu_pkg::data_w-1:0] mem_word(
        input logic [rdu_pkg::addr_w-1:0] a);
        if (a < rdu_pkg::diag_base) begin
            return mirror[a];
        end
        return rdu_pkg::diag_word[2'(a - rdu_pkg::diag_base)];
    endfunction

    task automatic predict_run(input logic [rdu_pkg::addr_w-1:0] b,
                               input logic [rdu_pkg::n_lane-1:0] ff,
                               output rdu_pkg::cal_out_t exp_out);
        logic [rdu_pkg::data_w-1:0] sum;
        logic [rdu_pkg::data_w-1:0] gold;
        logic [rdu_pkg::data_w-1:0] r0;
        logic [rdu_pkg::data_w-1:0] r1;
        logic [rdu_pkg::data_w-1:0] g0;
        logic [rdu_pkg::data_w-1:0] g1;
        logic                       e0;
        logic                       e1;
        int                         k;
        sum  = '0;
        gold = '0;
        // Window wraps mod 16
        // Golden is the sum of the diagnostic rows
        for (k = 0; k < rdu_pkg::win_len; k++) begin
            sum  = sum + mem_word(4'(int'(b) + k));
            gold = gold + mem_word(4'(int'(rdu_pkg::diag_base) + k));
        end
        r0 = sum ^ (ff[0] ? rdu_pkg::force_mask[0] : '0);
        r1 = sum ^ (ff[1] ? rdu_pkg::force_mask[1] : '0);
        // Mismatch enters diagnosis only while no fault is latched
        if ((r0 != r1) && !m_rdu_fault) begin
            g0 = gold ^ (ff[0] ? rdu_pkg::force_mask[0] : '0);
            g1 = gold ^ (ff[1] ? rdu_pkg::force_mask[1] : '0);
            e0 = (g0 != gold);
            e1 = (g1 != gold);
            if (!e0) begin
                m_lane = 1'b0;
            end else if (!e1) begin
                m_lane = 1'b1;
            end
            m_rdu_fault = e0 | e1;
            m_hw_fault  = e0 & e1;
        end
        exp_out = '{done: 1'b1, result: (m_lane ? r1 : r0), lane: m_lane,
                    rdu_fault: m_rdu_fault, hw_fault: m_hw_fault};
    endtask

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic apply_reset();
        fault_force = '0;
        rst_req     = 1'b1;
        tick();
        rst_req = 1'b0;
        while (!rst_sys_n) begin
            tick();
        end
        tick();
        clear_model();
    endtask

    task automatic write_word(input logic [rdu_pkg::addr_w-1:0] a,
                              input logic [rdu_pkg::data_w-1:0] d);
        host_wr = '{en: 1'b1, addr: a, data: d};
        tick();
        host_wr.en = 1'b0;
        // Diagnostic rows stay fixed
        if (a < rdu_pkg::diag_base) begin
            mirror[a] = d;
        end
    endtask

    task automatic fill_rows();
        int k;
        for (k = 0; k < int'(rdu_pkg::diag_base); k++) begin
            write_word(4'(k), $random(seed));
        end
    endtask

    // One calculation with its result and a single-cycle done checked
    task automatic run_calc(input logic [rdu_pkg::addr_w-1:0] b,
                            input logic [rdu_pkg::n_lane-1:0] ff);
        rdu_pkg::cal_out_t exp_out;
        int                waited;
        predict_run(b, ff, exp_out);
        fault_force = ff;
        opnd_base   = b;
        start       = 1'b1;
        tick();
        start  = 1'b0;
        waited = 0;
        while (!cal_out.done) begin
            if (waited >= cycle_limit) begin
                abort_run($sformatf("Timeout: no cal_out.done within %0d cycles of start",
                                    cycle_limit));
            end
            tick();
            waited++;
        end
        check_out(cal_out, exp_out);
        tick();
        check_flag("cal_out.done", cal_out.done, 1'b0);
    endtask

    // Start while chn_en is low must not complete
    task automatic start_blocked(input logic [rdu_pkg::addr_w-1:0] b);
        int k;
        opnd_base = b;
        start     = 1'b1;
        tick();
        start = 1'b0;
        for (k = 0; k < cycle_limit; k++) begin
            if (cal_out.done) begin
                abort_run("cal_out.done pulsed after a start issued with chn_en low");
            end
            tick();
        end
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin : watchdog
        #(watchdog_ns);
        abort_run($sformatf("Watchdog expired after %0d ns, the run hung", watchdog_ns));
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int                          k;
        logic [rdu_pkg::addr_w-1:0]  a;
        logic [rdu_pkg::data_w-1:0]  d;
        host_wr     = '0;
        start       = 1'b0;
        opnd_base   = '0;
        chn_en      = 1'b1;
        fault_force = '0;
        rst_req     = 1'b0;
        clear_model();
        // Power-on reset
        tick();
        while (!rst_sys_n) begin
            tick();
        end
        tick();

        // Random contents followed by unforced runs
        for (k = 0; k < n_rand_writes; k++) begin
            a = 4'($random(seed));
            d = $random(seed);
            write_word(a, d);
        end
        for (k = 0; k < n_rand_runs; k++) begin
            a = 4'($random(seed));
            run_calc(a, 2'b00);
        end

        // Read-only rows and window wrap
        for (k = int'(rdu_pkg::diag_base); k < 16; k++) begin
            write_word(4'(k), $random(seed));
        end
        write_word(4'd10, $random(seed));
        write_word(4'd11, $random(seed));
        run_calc(4'd10, 2'b00);
        run_calc(4'd14, 2'b00);

        // Channel disabled
        chn_en = 1'b0;
        for (k = 0; k < n_blocked; k++) begin
            start_blocked(4'($random(seed)));
        end
        chn_en = 1'b1;
        run_calc(4'($random(seed)), 2'b00);

        // Lane 0 forced with recovery on lane 1
        apply_reset();
        fill_rows();
        for (k = 0; k < n_force0_runs; k++) begin
            a = 4'($random(seed));
            run_calc(a, 2'b01);
        end

        // Both lanes forced into a hardware fault
        apply_reset();
        fill_rows();
        run_calc(4'($random(seed)), 2'b11);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* rdu_calc.f */
logic/rdu_pkg.sv
logic/opnd_mem.sv
logic/mem_arb.sv
logic/calc_lane.sv
logic/cal_seq.sv
logic/rdu_diag.sv
logic/rdu_top.sv
tb/tb_clkgen.sv
tb/tb_rdu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the rdu_calc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f rdu_calc.f --top-module tb_rdu -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_rdu" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Verdict from the log
if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
